// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // address and line geometry
    localparam int XLEN     = 32;
    localparam int LINE_W   = 26;  // 64-byte lines
    localparam int OFFSET_W = 6;

    // cacheline branch predictor
    localparam int BHR_W     = 10;
    localparam int PHT_DEPTH = 1024;

    // return address stack
    localparam int RAS_DEPTH = 8;
    localparam int RAS_PTR_W = 3;

    typedef logic [XLEN-1:0]   addr_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [BHR_W-1:0]  bhr_t;

    typedef struct packed {
        line_t               line;    // upper bits select the cacheline
        logic [OFFSET_W-1:0] offset;  // byte within the line
    } fetch_parts_t;

    // same word seen flat or split into line and offset
    typedef union packed {
        addr_t        flat;
        fetch_parts_t parts;
    } fetch_addr_u;

endpackage

`default_nettype wire

// File: rtl/ras.sv
`timescale 1ns/1ps
`default_nettype none

module ras import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  valid_in,
    input  logic  push,
    input  logic  pop,
    input  addr_t data_in,
    output addr_t top,
    output logic  valid,
    output logic  empty,
    output logic  full
);

    addr_t                stack [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] ptr;        // next free slot, wraps on overflow
    logic [RAS_PTR_W-1:0] top_ptr;
    logic [RAS_PTR_W:0]   count;      // occupancy, saturates at depth

    logic do_push;
    logic do_pop;

    assign top_ptr = ptr - 1'b1;

    assign do_push = valid_in & push;
    assign do_pop  = valid_in & pop & ~empty;  // pop of empty stack ignored

    // pointer and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr   <= '0;
            count <= '0;
        end else if (do_push && do_pop) begin
            ptr   <= ptr;  // top replaced in place
            count <= count;
        end else if (do_push) begin
            ptr <= ptr + 1'b1;
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (do_pop) begin
            ptr   <= top_ptr;
            count <= count - 1'b1;
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (do_push && do_pop) begin
            stack[top_ptr] <= data_in;
        end else if (do_push) begin
            stack[ptr] <= data_in;  // overwrites oldest when full
        end
    end

    assign top   = stack[top_ptr];
    assign empty = (count == '0);
    assign full  = (count == (RAS_PTR_W+1)'(RAS_DEPTH));
    assign valid = ~empty;

endmodule

`default_nettype wire

// File: rtl/clbp.sv
`timescale 1ns/1ps
`default_nettype none

module clbp import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  line_t clc,

    input  logic  bp_update_d1,
    input  logic  taken_d1,
    input  bhr_t  bhr_update_d1,

    input  logic  bp_update_br,
    input  logic  taken_br,
    input  bhr_t  bhr_update_br,

    input  logic  bp_update_rob,
    input  logic  taken_rob,
    input  bhr_t  bhr_update_rob,

    output logic  pred_taken
);

    logic [1:0] pht [PHT_DEPTH];  // two-bit saturating counters
    bhr_t       bhr;

    logic       upd_valid;
    logic       upd_taken;
    bhr_t       upd_idx;
    logic [1:0] upd_cnt;
    bhr_t       rd_idx;

    // training source, rob beats d1 beats br
    always_comb begin
        upd_valid = 1'b1;
        upd_taken = 1'b0;
        upd_idx   = '0;
        if (bp_update_rob) begin
            upd_taken = taken_rob;
            upd_idx   = bhr_update_rob;
        end else if (bp_update_d1) begin
            upd_taken = taken_d1;
            upd_idx   = bhr_update_d1;
        end else if (bp_update_br) begin
            upd_taken = taken_br;
            upd_idx   = bhr_update_br;
        end else begin
            upd_valid = 1'b0;
        end
    end

    assign upd_cnt = pht[upd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            bhr <= '0;
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht[i] <= 2'b01;  // weakly not-taken
            end
        end else if (upd_valid) begin
            bhr <= upd_idx;
            if (upd_taken) begin
                if (upd_cnt != 2'b11) begin
                    pht[upd_idx] <= upd_cnt + 2'b01;
                end
            end else if (upd_cnt != 2'b00) begin
                pht[upd_idx] <= upd_cnt - 2'b01;
            end
        end
    end

    // gshare style hash of line and history
    assign rd_idx     = clc[BHR_W-1:0] ^ bhr;
    assign pred_taken = pht[rd_idx][1];

endmodule

`default_nettype wire

// File: rtl/fetch_line_counter.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_line_counter import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall_in,
    input  logic  resteer,

    input  addr_t target_d1,
    input  logic  taken_d1,
    input  addr_t target_br,
    input  logic  taken_br,
    input  addr_t target_rob,
    input  logic  taken_rob,

    input  addr_t ras_top,
    input  logic  ras_valid,

    output line_t clc,
    output line_t clc_even,
    output line_t clc_odd
);

    fetch_addr_u rob_addr;
    fetch_addr_u d1_addr;
    fetch_addr_u br_addr;
    fetch_addr_u ras_addr;

    line_t clc_next;
    line_t clc_inc;

    assign rob_addr.flat = target_rob;
    assign d1_addr.flat  = target_d1;
    assign br_addr.flat  = target_br;
    assign ras_addr.flat = ras_top;

    assign clc_inc = clc + 1'b1;

    // one rule per edge, first match wins
    always_comb begin
        clc_next = clc;
        if (stall_in) begin
            clc_next = clc;
        end else if (resteer) begin
            if (taken_rob) begin
                clc_next = rob_addr.parts.line;
            end else if (taken_d1) begin
                clc_next = d1_addr.parts.line;
            end else if (taken_br) begin
                clc_next = br_addr.parts.line;
            end else if (ras_valid) begin
                clc_next = ras_addr.parts.line;  // fall back on return address
            end
            // nothing valid, hold
        end else begin
            clc_next = clc_inc;  // sequential fetch
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            clc <= '0;
        end else begin
            clc <= clc_next;
        end
    end

    // bank split, neighbour line goes to the other bank as prefetch
    always_comb begin
        if (!clc[0]) begin
            clc_even = clc;
            clc_odd  = clc_inc;
        end else begin
            clc_even = clc_inc;
            clc_odd  = clc;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_line_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_line_top import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall_in,
    input  logic  resteer,

    input  logic  bp_update_d1,
    input  addr_t resteer_target_d1,
    input  logic  resteer_taken_d1,
    input  bhr_t  bhr_update_d1,

    input  logic  bp_update_br,
    input  addr_t resteer_target_br,
    input  logic  resteer_taken_br,
    input  bhr_t  bhr_update_br,

    input  logic  bp_update_rob,
    input  addr_t resteer_target_rob,
    input  logic  resteer_taken_rob,
    input  bhr_t  bhr_update_rob,

    input  logic  ras_push,
    input  logic  ras_pop,
    input  addr_t ras_ret_addr,
    input  logic  ras_valid_in,

    output line_t clc_even,
    output line_t clc_odd,
    output logic  pred_taken,
    output logic  ras_empty
);

    addr_t ras_top;
    logic  ras_valid;
    line_t clc;

    ras u_ras (
        .clk      (clk),
        .rst      (rst),
        .valid_in (ras_valid_in),
        .push     (ras_push),
        .pop      (ras_pop),
        .data_in  (ras_ret_addr),
        .top      (ras_top),
        .valid    (ras_valid),
        .empty    (ras_empty),
        .full     ()
    );

    fetch_line_counter u_flc (
        .clk        (clk),
        .rst        (rst),
        .stall_in   (stall_in),
        .resteer    (resteer),
        .target_d1  (resteer_target_d1),
        .taken_d1   (resteer_taken_d1),
        .target_br  (resteer_target_br),
        .taken_br   (resteer_taken_br),
        .target_rob (resteer_target_rob),
        .taken_rob  (resteer_taken_rob),
        .ras_top    (ras_top),
        .ras_valid  (ras_valid),
        .clc        (clc),
        .clc_even   (clc_even),
        .clc_odd    (clc_odd)
    );

    clbp u_clbp (
        .clk            (clk),
        .rst            (rst),
        .clc            (clc),
        .bp_update_d1   (bp_update_d1),
        .taken_d1       (resteer_taken_d1),
        .bhr_update_d1  (bhr_update_d1),
        .bp_update_br   (bp_update_br),
        .taken_br       (resteer_taken_br),
        .bhr_update_br  (bhr_update_br),
        .bp_update_rob  (bp_update_rob),
        .taken_rob      (resteer_taken_rob),
        .bhr_update_rob (bhr_update_rob),
        .pred_taken     (pred_taken)
    );

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    localparam int PERIOD_NS  = 40;
    localparam int RST_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops right after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: dv/fetch_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_assert import fetch_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  stall_in,
    input line_t clc,
    input line_t clc_even,
    input line_t clc_odd
);

    int fail_count = 0;  // read by the testbench

    even_bank_a: assert property (@(posedge clk) disable iff (rst) !clc_even[0])
        else begin
            $error("even bank line has bit 0 set");
            fail_count++;
        end

    odd_bank_a: assert property (@(posedge clk) disable iff (rst) clc_odd[0])
        else begin
            $error("odd bank line has bit 0 clear");
            fail_count++;
        end

    // neighbour line sits next to the current one, wrap included
    bank_pair_a: assert property (@(posedge clk) disable iff (rst)
        (clc_odd == line_t'(clc_even + 1'b1)) || (clc_even == line_t'(clc_odd + 1'b1)))
        else begin
            $error("even and odd bank lines are not neighbours");
            fail_count++;
        end

    stall_hold_a: assert property (@(posedge clk) disable iff (rst)
        stall_in |=> $stable(clc))
        else begin
            $error("line moved while stalled");
            fail_count++;
        end

endmodule

bind fetch_line_counter fetch_assert u_fetch_assert (
    .clk      (clk),
    .rst      (rst),
    .stall_in (stall_in),
    .clc      (clc),
    .clc_even (clc_even),
    .clc_odd  (clc_odd)
);

`default_nettype wire

// File: dv/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int TEST_CYCLES = 400;  // upper bound over all test phases

    logic  clk;
    logic  rst;
    logic  stall_in;
    logic  resteer;
    logic  bp_update_d1;
    addr_t resteer_target_d1;
    logic  resteer_taken_d1;
    bhr_t  bhr_update_d1;
    logic  bp_update_br;
    addr_t resteer_target_br;
    logic  resteer_taken_br;
    bhr_t  bhr_update_br;
    logic  bp_update_rob;
    addr_t resteer_target_rob;
    logic  resteer_taken_rob;
    bhr_t  bhr_update_rob;
    logic  ras_push;
    logic  ras_pop;
    addr_t ras_ret_addr;
    logic  ras_valid_in;
    line_t clc_even;
    line_t clc_odd;
    logic  pred_taken;
    logic  ras_empty;

    // reference model state
    line_t      m_clc;
    addr_t      m_ras[$];
    logic [1:0] m_pht [PHT_DEPTH];
    bhr_t       m_bhr;

    logic [15:0] lfsr = 16'd55;
    int          errors = 0;

    clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    fetch_line_top DUT (.*);

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16 14 13 11
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic addr_t make_target(input line_t l, input logic [OFFSET_W-1:0] off);
        fetch_addr_u u;
        u.parts.line   = l;
        u.parts.offset = off;
        return u.flat;
    endfunction

    // expected line after one edge
    function automatic line_t next_line(
        input line_t cur,
        input logic  stall,
        input logic  rs,
        input logic  tk_rob,
        input logic  tk_d1,
        input logic  tk_br,
        input addr_t tg_rob,
        input addr_t tg_d1,
        input addr_t tg_br,
        input logic  ras_ok,
        input addr_t ras_tgt
    );
        if (stall) return cur;
        if (!rs) return line_t'(cur + 1'b1);
        if (tk_rob) return tg_rob[XLEN-1:OFFSET_W];
        if (tk_d1) return tg_d1[XLEN-1:OFFSET_W];
        if (tk_br) return tg_br[XLEN-1:OFFSET_W];
        if (ras_ok) return ras_tgt[XLEN-1:OFFSET_W];
        return cur;
    endfunction

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // bound checker in the line counter counts its own failures
    task automatic check_assertions();
        if (DUT.u_flc.u_fetch_assert.fail_count != 0) begin
            errors++;
            $display("a concurrent assertion in the line counter failed");
            $display("tests failed");
            $fatal(1, "stopping at first assertion failure");
        end
    endtask

    task automatic reset_model();
        m_clc = '0;
        m_ras.delete();
        m_bhr = '0;
        for (int i = 0; i < PHT_DEPTH; i++) begin
            m_pht[i] = 2'b01;
        end
    endtask

    task automatic advance_model();
        logic  ras_ok;
        addr_t ras_tgt;
        logic  upd;
        logic  tk;
        bhr_t  idx;
        ras_ok  = (m_ras.size() != 0);
        ras_tgt = ras_ok ? m_ras[m_ras.size()-1] : '0;
        m_clc = next_line(m_clc, stall_in, resteer, resteer_taken_rob, resteer_taken_d1,
                          resteer_taken_br, resteer_target_rob, resteer_target_d1,
                          resteer_target_br, ras_ok, ras_tgt);
        if (ras_valid_in) begin
            if (ras_push && ras_pop && ras_ok) begin
                m_ras[m_ras.size()-1] = ras_ret_addr;
            end else if (ras_push) begin
                if (m_ras.size() == RAS_DEPTH) void'(m_ras.pop_front());  // oldest lost
                m_ras.push_back(ras_ret_addr);
            end else if (ras_pop && ras_ok) begin
                void'(m_ras.pop_back());
            end
        end
        upd = 1'b1;
        tk  = 1'b0;
        idx = '0;
        if (bp_update_rob) begin
            tk  = resteer_taken_rob;
            idx = bhr_update_rob;
        end else if (bp_update_d1) begin
            tk  = resteer_taken_d1;
            idx = bhr_update_d1;
        end else if (bp_update_br) begin
            tk  = resteer_taken_br;
            idx = bhr_update_br;
        end else begin
            upd = 1'b0;
        end
        if (upd) begin
            m_bhr = idx;
            if (tk && m_pht[idx] != 2'b11) m_pht[idx] = m_pht[idx] + 2'b01;
            else if (!tk && m_pht[idx] != 2'b00) m_pht[idx] = m_pht[idx] - 2'b01;
        end
    endtask

    // compare shortly after each edge, inputs only move on the falling edge
    always begin
        line_t e_even;
        line_t e_odd;
        @(posedge clk);
        if (rst) reset_model();
        else advance_model();
        #1;
        e_even = m_clc[0] ? line_t'(m_clc + 1'b1) : m_clc;
        e_odd  = m_clc[0] ? m_clc : line_t'(m_clc + 1'b1);
        check_line("clc_even", e_even, clc_even);
        check_line("clc_odd", e_odd, clc_odd);
        check_bit("pred_taken", m_pht[m_clc[BHR_W-1:0] ^ m_bhr][1], pred_taken);
        check_bit("ras_empty", m_ras.size() == 0, ras_empty);
        check_assertions();
    end

    task automatic clear_inputs();
        stall_in           = 1'b0;
        resteer            = 1'b0;
        bp_update_d1       = 1'b0;
        resteer_target_d1  = '0;
        resteer_taken_d1   = 1'b0;
        bhr_update_d1      = '0;
        bp_update_br       = 1'b0;
        resteer_target_br  = '0;
        resteer_taken_br   = 1'b0;
        bhr_update_br      = '0;
        bp_update_rob      = 1'b0;
        resteer_target_rob = '0;
        resteer_taken_rob  = 1'b0;
        bhr_update_rob     = '0;
        ras_push           = 1'b0;
        ras_pop            = 1'b0;
        ras_ret_addr       = '0;
        ras_valid_in       = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
        end
    endtask

    task automatic hold(input int n);
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
            stall_in = 1'b1;
        end
    endtask

    // random resteers, full adds stall, training and stack traffic
    task automatic random_cycles(input int n, input logic full);
        logic [31:0] r;
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
            rand_bits(2, r);
            resteer = (r[1:0] != 2'b00);
            rand_bits(3, r);
            {resteer_taken_rob, resteer_taken_d1, resteer_taken_br} = r[2:0];
            rand_bits(32, r);
            resteer_target_rob = r;
            rand_bits(32, r);
            resteer_target_d1 = r;
            rand_bits(32, r);
            resteer_target_br = r;
            if (full) begin
                rand_bits(2, r);
                stall_in = (r[1:0] == 2'b00);
                rand_bits(3, r);
                {bp_update_rob, bp_update_d1, bp_update_br} = r[2:0];
                rand_bits(BHR_W, r);
                bhr_update_rob = r[BHR_W-1:0];
                rand_bits(BHR_W, r);
                bhr_update_d1 = r[BHR_W-1:0];
                rand_bits(BHR_W, r);
                bhr_update_br = r[BHR_W-1:0];
                rand_bits(3, r);
                {ras_valid_in, ras_push, ras_pop} = r[2:0];
                rand_bits(32, r);
                ras_ret_addr = r;
            end
        end
    endtask

    // stall wins over a resteer in the same cycle
    task automatic stall_burst(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(negedge clk);
            clear_inputs();
            stall_in          = 1'b1;
            resteer           = 1'b1;
            resteer_taken_rob = 1'b1;
            rand_bits(32, r);
            resteer_target_rob = r;
        end
    endtask

    task automatic push_addr(input addr_t a, input logic v);
        @(negedge clk);
        clear_inputs();
        ras_valid_in = v;
        ras_push     = 1'b1;
        ras_ret_addr = a;
    endtask

    task automatic pop_only(input logic v);
        @(negedge clk);
        clear_inputs();
        ras_valid_in = v;
        ras_pop      = 1'b1;
    endtask

    task automatic return_pop();  // resteer to stack top and pop it
        @(negedge clk);
        clear_inputs();
        resteer      = 1'b1;
        ras_valid_in = 1'b1;
        ras_pop      = 1'b1;
    endtask

    task automatic resteer_to(input line_t l);
        @(negedge clk);
        clear_inputs();
        resteer            = 1'b1;
        resteer_taken_rob  = 1'b1;
        resteer_target_rob = make_target(l, 6'h11);
    endtask

    task automatic train(input int src, input bhr_t idx, input logic tk);
        @(negedge clk);
        clear_inputs();
        stall_in = 1'b1;  // keep the line still while training
        case (src)
            0: {bp_update_rob, resteer_taken_rob, bhr_update_rob} = {1'b1, tk, idx};
            1: {bp_update_d1, resteer_taken_d1, bhr_update_d1} = {1'b1, tk, idx};
            default: {bp_update_br, resteer_taken_br, bhr_update_br} = {1'b1, tk, idx};
        endcase
    endtask

    task automatic dual_train(input bhr_t idx_rob, input bhr_t idx_br);
        @(negedge clk);
        clear_inputs();
        stall_in = 1'b1;
        {bp_update_rob, resteer_taken_rob, bhr_update_rob} = {1'b1, 1'b1, idx_rob};
        {bp_update_br, resteer_taken_br, bhr_update_br} = {1'b1, 1'b1, idx_br};
    endtask

    initial begin
        #(TEST_CYCLES * CLK_PERIOD * 2);
        $display("timeout after %0d cycles without reaching the end", TEST_CYCLES * 2);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] r;
        bhr_t        idx_a;
        bhr_t        idx_b;
        clear_inputs();
        @(negedge clk);
        while (rst !== 1'b0) @(negedge clk);

        // reset values, then plain sequential fetch
        check_line("clc_even", 26'd0, clc_even);
        check_line("clc_odd", 26'd1, clc_odd);
        check_bit("pred_taken", 1'b0, pred_taken);
        check_bit("ras_empty", 1'b1, ras_empty);
        idle(20);

        // resteer priority, first with an empty stack then with one entry
        random_cycles(40, 1'b0);
        push_addr(make_target(26'h3333, 6'h2a), 1'b1);
        random_cycles(40, 1'b0);

        repeat (5) begin
            rand_bits(3, r);
            stall_burst(int'(r[2:0]) + 1);
            idle(2);
        end

        // return address stack
        repeat (RAS_DEPTH) pop_only(1'b1);
        idle(1);
        check_bit("ras_empty", 1'b1, ras_empty);
        for (int i = 0; i < 3; i++) begin
            push_addr(make_target(line_t'(26'h1000 + i), 6'(i)), 1'b1);
        end
        repeat (3) return_pop();
        idle(1);
        check_bit("ras_empty", 1'b1, ras_empty);
        for (int i = 0; i < RAS_DEPTH + 1; i++) begin
            push_addr(make_target(line_t'(26'h2000 + i), 6'h00), 1'b1);
        end
        repeat (RAS_DEPTH) return_pop();
        return_pop();  // first push was overwritten, nothing left
        hold(1);
        check_line("clc_odd", 26'h2001, clc_odd);
        check_bit("ras_empty", 1'b1, ras_empty);
        repeat (3) pop_only(1'b1);
        hold(1);
        check_bit("ras_empty", 1'b1, ras_empty);
        push_addr(make_target(26'h55, 6'h00), 1'b0);
        hold(1);
        check_bit("ras_empty", 1'b1, ras_empty);
        push_addr(make_target(26'h56, 6'h00), 1'b1);
        pop_only(1'b0);
        hold(1);
        check_bit("ras_empty", 1'b0, ras_empty);
        pop_only(1'b1);
        hold(1);
        check_bit("ras_empty", 1'b1, ras_empty);

        // predictor saturation and recovery
        idx_a = 10'h2a5;
        repeat (4) train(0, idx_a, 1'b1);
        resteer_to(26'h400);
        hold(1);
        check_bit("pred_taken", 1'b1, pred_taken);
        repeat (2) train(1, idx_a, 1'b0);
        hold(1);
        check_bit("pred_taken", 1'b0, pred_taken);

        // rob and br together, only rob trains
        idx_a = 10'h0f0;
        idx_b = 10'h10f;
        repeat (2) dual_train(idx_a, idx_b);
        hold(1);
        check_bit("pred_taken", 1'b1, pred_taken);
        resteer_to(line_t'(26'h800) | line_t'(idx_a ^ idx_b));
        hold(1);
        check_bit("pred_taken", 1'b0, pred_taken);

        random_cycles(100, 1'b1);
        idle(4);

        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/fetch_pkg.sv
rtl/ras.sv
rtl/clbp.sv
rtl/fetch_line_counter.sv
rtl/fetch_line_top.sv
dv/clk_gen.sv
dv/fetch_assert.sv
dv/fetch_tb.sv
